//--- axi_rd_guard_top.f
logic/guard_pkg.sv
logic/guard_tick.sv
logic/read_guard.sv
logic/guard_regs.sv
logic/axi_rd_guard_top.sv
tb/tb_axi_rd_guard.sv

//--- Makefile
# Verilator build and run of the AXI read guard testbench

SIM = obj_dir/Vtb_axi_rd_guard

.PHONY: all run clean

all: $(SIM)

$(SIM): axi_rd_guard_top.f $(wildcard logic/*.sv tb/*.sv)
	verilator --binary --timing --top-module tb_axi_rd_guard \
		-f axi_rd_guard_top.f -o Vtb_axi_rd_guard

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

//--- tb/tb_axi_rd_guard.sv
/*
 * Directed testbench of the AXI read guard: Wishbone and AXI tap drivers,
 * typed compare tasks and one task per tested behavior
 */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rd_guard;

  localparam int TickDiv = 4;
  localparam guard_pkg::wb_addr_t AdrCtrl    = 8'h00;
  localparam guard_pkg::wb_addr_t AdrBudget  = 8'h04;
  localparam guard_pkg::wb_addr_t AdrStatus  = 8'h08;
  localparam guard_pkg::wb_addr_t AdrIrqAddr = 8'h0C;
  localparam guard_pkg::wb_addr_t AdrLatency = 8'h10;

  logic               clk, rst_n, irq, reset_req;
  guard_pkg::rd_req_t mst_req;
  guard_pkg::rd_rsp_t slv_rsp;
  guard_pkg::wb_req_t wb_req;
  guard_pkg::wb_rsp_t wb_rsp;

  // Own record of outstanding reads in issue order
  guard_pkg::id_t  out_id[$];
  guard_pkg::len_t out_len[$];
  int unsigned     cur_budget;
  integer          seed;
  int              errors, passed, failed;

  axi_rd_guard_top u_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .mst_req_i   (mst_req),
    .slv_rsp_i   (slv_rsp),
    .wb_i        (wb_req),
    .wb_o        (wb_rsp),
    .irq_o       (irq),
    .reset_req_o (reset_req)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_cnt(input string what, input guard_pkg::cnt_t got, exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string what, input guard_pkg::addr_t got, exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_id(input string what, input guard_pkg::id_t got, exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_data(input string what, input guard_pkg::wb_data_t got, exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic wb_access(input logic we, input guard_pkg::wb_addr_t adr,
                           input guard_pkg::wb_data_t wdat,
                           output guard_pkg::wb_data_t rdat);
    int n;
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_rsp.ack && n < 10);
    if (!wb_rsp.ack) begin
      $display("No Wishbone ack for address %h within 10 cycles at %0t", adr, $time);
      errors++;
    end
    rdat   = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic wb_write(input guard_pkg::wb_addr_t adr, input guard_pkg::wb_data_t dat);
    guard_pkg::wb_data_t unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input guard_pkg::wb_addr_t adr, output guard_pkg::wb_data_t dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  // Budget times all outstanding lengths plus the new one divided by 32
  function automatic guard_pkg::cnt_t expected_load(input guard_pkg::len_t len);
    int unsigned sum;
    sum = 32'(len);
    foreach (out_len[i]) sum = sum + 32'(out_len[i]);
    return guard_pkg::cnt_t'((cur_budget * sum) / 32);
  endfunction

  function automatic int find_oldest(input guard_pkg::id_t id);
    foreach (out_id[i]) begin
      if (out_id[i] == id) return i;
    end
    return -1;
  endfunction

  task automatic send_ar(input guard_pkg::id_t id, input guard_pkg::addr_t addr,
                         input guard_pkg::len_t len, output guard_pkg::cnt_t loaded);
    @(negedge clk);
    loaded = expected_load(len);
    mst_req.ar = '{id: id, addr: addr, len: len};
    mst_req.ar_valid = 1'b1;
    slv_rsp.ar_ready = 1'b1;
    @(negedge clk);
    mst_req.ar_valid = 1'b0;
    slv_rsp.ar_ready = 1'b0;
    out_id.push_back(id);
    out_len.push_back(len);
  endtask

  task automatic send_r(input guard_pkg::id_t id);
    int idx;
    @(negedge clk);
    slv_rsp.r_id    = id;
    slv_rsp.r_last  = 1'b1;
    slv_rsp.r_valid = 1'b1;
    mst_req.r_ready = 1'b1;
    @(negedge clk);
    slv_rsp.r_valid = 1'b0;
    slv_rsp.r_last  = 1'b0;
    mst_req.r_ready = 1'b0;
    idx = find_oldest(id);
    if (idx >= 0) begin
      out_id.delete(idx);
      out_len.delete(idx);
    end
  endtask

  task automatic wait_irq(input int limit, output int cycles);
    cycles = 0;
    while (!irq && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!irq) begin
      $display("irq_o did not rise within %0d cycles at %0t", limit, $time);
      errors++;
    end
  endtask

  // CTRL write drops irq and reset request and empties STATUS
  task automatic clear_and_check();
    guard_pkg::wb_data_t data;
    wb_write(AdrCtrl, 32'h1);
    @(negedge clk);
    check_bit("irq_o after clear", irq, 1'b0);
    check_bit("reset_req_o after clear", reset_req, 1'b0);
    wb_read(AdrStatus, data);
    check_data("STATUS after clear", data, '0);
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      passed++;
      $display("%s: passed", name);
    end else begin
      failed++;
      $display("%s: failed with %0d errors", name, errors - err0);
    end
  endtask

  task automatic register_access();
    guard_pkg::wb_data_t data;
    int err0;
    err0 = errors;
    check_bit("irq_o after reset", irq, 1'b0);
    check_bit("reset_req_o after reset", reset_req, 1'b0);
    check_bit("ack after reset", wb_rsp.ack, 1'b0);
    wb_read(AdrBudget, data);
    check_cnt("BUDGET reset value", data[15:0], 16'h0100);
    wb_read(AdrStatus, data);
    check_data("STATUS reset value", data, '0);
    wb_write(AdrBudget, 32'h1234);
    wb_read(AdrBudget, data);
    check_cnt("BUDGET readback", data[15:0], 16'h1234);
    wb_write(AdrBudget, 32'h0100);
    cur_budget = 32'h0100;
    report_test("register access", err0);
  endtask

  task automatic in_time_completion();
    guard_pkg::wb_data_t data;
    guard_pkg::cnt_t     loaded, lat;
    logic                seen;
    int                  err0;
    err0 = errors;
    send_ar(4'd3, 32'h0000_4000, 8'd3, loaded);
    repeat (4) @(negedge clk);
    send_r(4'd3);
    repeat (2) @(negedge clk);
    wb_read(AdrLatency, data);
    lat = data[15:0];
    check_bit("LATENCY within loaded count", (lat != '0) && (lat <= loaded), 1'b1);
    seen = 1'b0;
    for (int n = 0; n < (int'(loaded) + 1) * TickDiv + 3; n++) begin
      @(negedge clk);
      if (irq) seen = 1'b1;
    end
    check_bit("irq after in-time completion", seen, 1'b0);
    report_test("in-time completion", err0);
  endtask

  task automatic timeout_window();
    guard_pkg::wb_data_t data;
    guard_pkg::cnt_t     loaded;
    int                  cycles, err0;
    err0 = errors;
    wb_write(AdrBudget, 32'h20);
    cur_budget = 32'h20;
    send_ar(4'd5, 32'hdead_bee0, 8'd3, loaded);
    wait_irq((int'(loaded) + 1) * TickDiv + 3, cycles);
    check_bit("timeout not too early", cycles >= int'(loaded) * TickDiv - TickDiv, 1'b1);
    check_bit("reset_req_o on timeout", reset_req, 1'b1);
    out_id.delete();
    out_len.delete();
    wb_read(AdrStatus, data);
    check_bit("STATUS irq", data[0], 1'b1);
    check_bit("STATUS timeout", data[1], 1'b1);
    check_bit("STATUS unwanted", data[2], 1'b0);
    check_bit("STATUS reset pending", data[3], 1'b1);
    check_id("STATUS evt_id", data[11:8], 4'd5);
    wb_read(AdrIrqAddr, data);
    check_addr("IRQ_ADDR", data, 32'hdead_bee0);
    clear_and_check();
    wb_write(AdrBudget, 32'h0100);
    cur_budget = 32'h0100;
    report_test("timeout", err0);
  endtask

  task automatic unwanted_response();
    guard_pkg::wb_data_t data;
    int                  err0;
    err0 = errors;
    send_r(4'd9);
    // Both outputs rise in the cycle after the completing beat
    check_bit("irq_o on unwanted response", irq, 1'b1);
    check_bit("reset_req_o on unwanted response", reset_req, 1'b1);
    wb_read(AdrStatus, data);
    check_bit("STATUS irq", data[0], 1'b1);
    check_bit("STATUS timeout", data[1], 1'b0);
    check_bit("STATUS unwanted", data[2], 1'b1);
    check_id("STATUS evt_id", data[11:8], 4'd9);
    clear_and_check();
    report_test("unwanted response", err0);
  endtask

  task automatic ordering_under_load();
    guard_pkg::wb_data_t data;
    guard_pkg::cnt_t     loaded, lat;
    guard_pkg::id_t      id;
    guard_pkg::len_t     len;
    int                  rounds, err0;
    err0 = errors;
    // Fill the table with IDs drawn from four values
    for (int i = 0; i < 8; i++) begin
      id  = guard_pkg::id_t'((($random(seed) & 3) * 4) + 1);
      len = guard_pkg::len_t'(4 + ($random(seed) & 15));
      send_ar(id, guard_pkg::addr_t'(32'h1000 + i * 64), len, loaded);
    end
    // Round robin over IDs with the oldest first within each ID
    rounds = 0;
    while (out_id.size() > 0 && rounds < 16) begin
      for (int k = 0; k < 4; k++) begin
        id = guard_pkg::id_t'(k * 4 + 1);
        if (find_oldest(id) >= 0) send_r(id);
      end
      rounds++;
    end
    check_bit("irq_o after interleaved responses", irq, 1'b0);
    check_bit("reset_req_o after interleaved responses", reset_req, 1'b0);
    send_ar(4'd7, 32'h0000_8000, 8'd2, loaded);
    repeat (3) @(negedge clk);
    send_r(4'd7);
    repeat (2) @(negedge clk);
    wb_read(AdrLatency, data);
    lat = data[15:0];
    check_bit("LATENCY of fresh read", (lat != '0) && (lat <= loaded), 1'b1);
    wb_read(AdrStatus, data);
    check_data("STATUS after fresh read", data, '0);
    report_test("ordering under load", err0);
  endtask

  initial begin
    seed       = 32'hbabe;
    errors     = 0;
    passed     = 0;
    failed     = 0;
    cur_budget = 32'h0100;
    rst_n      = 1'b0;
    mst_req    = '0;
    slv_rsp    = '0;
    wb_req     = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    register_access();
    in_time_completion();
    timeout_window();
    unwanted_response();
    ordering_under_load();

    $display("tests passed: %0d, failed: %0d", passed, failed);
    if (failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/axi_rd_guard_top.sv
/*
 * Top level of the AXI read guard: prescaler, transaction guard and
 * Wishbone register file
 */
`timescale 1ns/1ps
`default_nettype none

module axi_rd_guard_top #(
  parameter int unsigned MaxUniqIds   = 4,
  parameter int unsigned MaxRdTxns    = 8,
  parameter int unsigned PrescalerDiv = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  guard_pkg::rd_req_t mst_req_i,
  input  guard_pkg::rd_rsp_t slv_rsp_i,
  input  guard_pkg::wb_req_t wb_i,
  output guard_pkg::wb_rsp_t wb_o,
  output logic               irq_o,
  output logic               reset_req_o
);

  logic                  tick;
  logic                  reset_req;
  guard_pkg::guard_cfg_t cfg;
  guard_pkg::guard_evt_t evt;

  guard_tick #(
    .PrescalerDiv (PrescalerDiv)
  ) u_tick (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tick_o (tick)
  );

  read_guard #(
    .MaxUniqIds (MaxUniqIds),
    .MaxRdTxns  (MaxRdTxns)
  ) u_guard (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tick_i      (tick),
    .mst_req_i   (mst_req_i),
    .slv_rsp_i   (slv_rsp_i),
    .cfg_i       (cfg),
    .evt_o       (evt),
    .reset_req_o (reset_req)
  );

  guard_regs u_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wb_i            (wb_i),
    .wb_o            (wb_o),
    .evt_i           (evt),
    .reset_pending_i (reset_req),
    .cfg_o           (cfg),
    .irq_o           (irq_o)
  );

  assign reset_req_o = reset_req;

endmodule

`default_nettype wire

//--- logic/guard_regs.sv
/*
 * Wishbone classic register file of the read guard: CTRL, BUDGET, STATUS,
 * IRQ_ADDR and LATENCY, event latching and the sticky interrupt
 */
`timescale 1ns/1ps
`default_nettype none

module guard_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  guard_pkg::wb_req_t    wb_i,
  output guard_pkg::wb_rsp_t    wb_o,
  input  guard_pkg::guard_evt_t evt_i,
  input  logic                  reset_pending_i,
  output guard_pkg::guard_cfg_t cfg_o,
  output logic                  irq_o
);

  localparam guard_pkg::wb_addr_t AdrCtrl    = 8'h00;
  localparam guard_pkg::wb_addr_t AdrBudget  = 8'h04;
  localparam guard_pkg::wb_addr_t AdrStatus  = 8'h08;
  localparam guard_pkg::wb_addr_t AdrIrqAddr = 8'h0C;
  localparam guard_pkg::wb_addr_t AdrLatency = 8'h10;

  logic                 wb_acc, wb_wr, guard_evt;
  logic                 ack_q, clear_q, irq_q;
  logic                 timeout_q, unwanted_q;
  guard_pkg::id_t       evt_id_q;
  guard_pkg::addr_t     evt_addr_q;
  guard_pkg::cnt_t      budget_q, latency_q;
  guard_pkg::wb_data_t  rdata, rdata_q;

  // Access starts one cycle before its ack
  assign wb_acc    = wb_i.cyc && wb_i.stb && !ack_q;
  assign wb_wr     = wb_acc && wb_i.we;
  assign guard_evt = evt_i.timeout || evt_i.unwanted;

  always_comb begin
    rdata = '0;
    case (wb_i.adr)
      AdrBudget:  rdata = 32'(budget_q);
      AdrStatus:  rdata = {20'b0, evt_id_q, 4'b0, reset_pending_i, unwanted_q,
                           timeout_q, irq_q};
      AdrIrqAddr: rdata = evt_addr_q;
      AdrLatency: rdata = 32'(latency_q);
      default:    rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      clear_q  <= 1'b0;
      budget_q <= 16'h0100;
    end else begin
      ack_q   <= wb_acc;
      // Clear pulse lines up with the ack
      clear_q <= wb_wr && (wb_i.adr == AdrCtrl) && wb_i.dat[0];
      if (wb_wr && (wb_i.adr == AdrBudget)) begin
        budget_q <= wb_i.dat[15:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_acc) begin
      rdata_q <= rdata;
    end
    if (guard_evt) begin
      evt_addr_q <= evt_i.evt_addr;
    end
    if (evt_i.done) begin
      latency_q <= evt_i.latency;
    end
  end

  // Status is sticky, a new event beats a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q      <= 1'b0;
      timeout_q  <= 1'b0;
      unwanted_q <= 1'b0;
      evt_id_q   <= '0;
    end else if (guard_evt) begin
      irq_q      <= 1'b1;
      timeout_q  <= timeout_q || evt_i.timeout;
      unwanted_q <= unwanted_q || evt_i.unwanted;
      evt_id_q   <= evt_i.evt_id;
    end else if (clear_q) begin
      irq_q      <= 1'b0;
      timeout_q  <= 1'b0;
      unwanted_q <= 1'b0;
      evt_id_q   <= '0;
    end
  end

  assign wb_o.ack     = ack_q;
  assign wb_o.dat     = rdata_q;
  assign cfg_o.budget = budget_q;
  assign cfg_o.clear  = clear_q;
  assign irq_o        = irq_q;

endmodule

`default_nettype wire

//--- logic/read_guard.sv
/*
 * Read transaction table with per-ID linked lists, budget load and countdown,
 * response matching, timeout and unwanted-response detection, reset request
 */
`timescale 1ns/1ps
`default_nettype none

module read_guard #(
  parameter int unsigned MaxUniqIds = 4,
  parameter int unsigned MaxRdTxns  = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  tick_i,
  input  guard_pkg::rd_req_t    mst_req_i,
  input  guard_pkg::rd_rsp_t    slv_rsp_i,
  input  guard_pkg::guard_cfg_t cfg_i,
  output guard_pkg::guard_evt_t evt_o,
  output logic                  reset_req_o
);

  // No more distinct IDs than entries can ever be live
  localparam int unsigned HtCap  = (MaxUniqIds <= MaxRdTxns) ? MaxUniqIds : MaxRdTxns;
  localparam int unsigned HtIdxW = (HtCap > 1) ? $clog2(HtCap) : 1;
  localparam int unsigned LdIdxW = (MaxRdTxns > 1) ? $clog2(MaxRdTxns) : 1;

  typedef logic [HtIdxW-1:0] ht_idx_t;
  typedef logic [LdIdxW-1:0] ld_idx_t;

  // One list per ID
  typedef struct packed {
    guard_pkg::id_t id;
    ld_idx_t        head;
    ld_idx_t        tail;
    logic           free;
  } ht_entry_t;

  // One outstanding read
  typedef struct packed {
    guard_pkg::ar_beat_t beat;
    guard_pkg::cnt_t     counter;
    logic                timeout;
    ld_idx_t             next;
    logic                free;
  } ld_entry_t;

  ht_entry_t [HtCap-1:0]     ht_d, ht_q;
  ld_entry_t [MaxRdTxns-1:0] ld_d, ld_q;

  logic            ar_fire, comp_beat;
  logic            comp_seen_q, dec_en;
  logic            rsp_found, rsp_hit;
  ht_idx_t         rsp_idx;
  ld_idx_t         rsp_head;
  logic            to_hit;
  ld_idx_t         to_idx;
  logic            flush;
  logic [15:0]     len_sum;
  logic [31:0]     load_prod;
  guard_pkg::cnt_t load_cnt;
  ld_entry_t       new_entry;
  logic            ld_free_found, ht_free_found, in_found;
  ld_idx_t         ld_free_idx;
  ht_idx_t         ht_free_idx, in_idx;
  logic            reset_req_q;

  assign ar_fire   = mst_req_i.ar_valid && slv_rsp_i.ar_ready;
  assign comp_beat = slv_rsp_i.r_valid && mst_req_i.r_ready && slv_rsp_i.r_last;

  // Completing beat since the last tick holds the countdown
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      comp_seen_q <= 1'b0;
    end else if (tick_i) begin
      comp_seen_q <= 1'b0;
    end else if (comp_beat) begin
      comp_seen_q <= 1'b1;
    end
  end

  assign dec_en = tick_i && !(comp_seen_q || comp_beat);

  // Look up the response ID
  always_comb begin
    rsp_found = 1'b0;
    rsp_idx   = '0;
    for (int i = 0; i < HtCap; i++) begin
      if (!ht_q[i].free && (ht_q[i].id == slv_rsp_i.r_id) && !rsp_found) begin
        rsp_found = 1'b1;
        rsp_idx   = ht_idx_t'(i);
      end
    end
  end

  assign rsp_hit  = comp_beat && rsp_found;
  assign rsp_head = ht_q[rsp_idx].head;

  // First expired entry
  always_comb begin
    to_hit = 1'b0;
    to_idx = '0;
    for (int i = 0; i < MaxRdTxns; i++) begin
      if (!ld_q[i].free && ld_q[i].timeout && !to_hit) begin
        to_hit = 1'b1;
        to_idx = ld_idx_t'(i);
      end
    end
  end

  assign flush = to_hit || (comp_beat && !rsp_found);

  // Burst lengths of everything outstanding
  always_comb begin
    len_sum = '0;
    for (int i = 0; i < MaxRdTxns; i++) begin
      if (!ld_q[i].free) begin
        len_sum = len_sum + 16'(ld_q[i].beat.len);
      end
    end
  end

  assign load_prod = 32'(cfg_i.budget) * 32'(len_sum + 16'(mst_req_i.ar.len));
  assign load_cnt  = guard_pkg::cnt_t'(load_prod >> 5);

  // A zero budget is expired right away
  assign new_entry = '{
    beat:    mst_req_i.ar,
    counter: load_cnt,
    timeout: (load_cnt == '0),
    next:    '0,
    free:    1'b0
  };

  always_comb begin : proc_table
    ht_d          = ht_q;
    ld_d          = ld_q;
    ld_free_found = 1'b0;
    ld_free_idx   = '0;
    ht_free_found = 1'b0;
    ht_free_idx   = '0;
    in_found      = 1'b0;
    in_idx        = '0;

    // Countdown sets the mark as the counter reaches zero
    for (int i = 0; i < MaxRdTxns; i++) begin
      if (!ld_q[i].free && dec_en && (ld_q[i].counter != '0)) begin
        ld_d[i].counter = ld_q[i].counter - 1'b1;
        if (ld_q[i].counter == guard_pkg::cnt_t'(1)) begin
          ld_d[i].timeout = 1'b1;
        end
      end
    end

    // Retire the oldest entry of the responding ID
    if (rsp_hit) begin
      ld_d[rsp_head] = '{free: 1'b1, default: '0};
      if (rsp_head == ht_q[rsp_idx].tail) begin
        ht_d[rsp_idx] = '{free: 1'b1, default: '0};
      end else begin
        ht_d[rsp_idx].head = ld_q[rsp_head].next;
      end
    end

    // Searches run on the updated table so freed slots are reused at once
    for (int i = 0; i < MaxRdTxns; i++) begin
      if (ld_d[i].free && !ld_free_found) begin
        ld_free_found = 1'b1;
        ld_free_idx   = ld_idx_t'(i);
      end
    end
    for (int i = 0; i < HtCap; i++) begin
      if (ht_d[i].free && !ht_free_found) begin
        ht_free_found = 1'b1;
        ht_free_idx   = ht_idx_t'(i);
      end
      if (!ht_d[i].free && (ht_d[i].id == mst_req_i.ar.id) && !in_found) begin
        in_found = 1'b1;
        in_idx   = ht_idx_t'(i);
      end
    end

    // Enqueue unless no slot is left
    if (ar_fire && ld_free_found) begin
      if (in_found) begin
        ld_d[ht_d[in_idx].tail].next = ld_free_idx;
        ht_d[in_idx].tail            = ld_free_idx;
        ld_d[ld_free_idx]            = new_entry;
      end else if (ht_free_found) begin
        ht_d[ht_free_idx] = '{
          id:   mst_req_i.ar.id,
          head: ld_free_idx,
          tail: ld_free_idx,
          free: 1'b0
        };
        ld_d[ld_free_idx] = new_entry;
      end
    end

    // Any event drops the whole table
    if (flush) begin
      for (int i = 0; i < MaxRdTxns; i++) begin
        ld_d[i] = '{free: 1'b1, default: '0};
      end
      for (int i = 0; i < HtCap; i++) begin
        ht_d[i] = '{free: 1'b1, default: '0};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < HtCap; i++) begin
        ht_q[i] <= '{free: 1'b1, default: '0};
      end
      for (int i = 0; i < MaxRdTxns; i++) begin
        ld_q[i] <= '{free: 1'b1, default: '0};
      end
    end else begin
      ht_q <= ht_d;
      ld_q <= ld_d;
    end
  end

  // Timeout wins over unwanted
  always_comb begin
    evt_o          = '0;
    evt_o.timeout  = to_hit;
    evt_o.unwanted = comp_beat && !rsp_found;
    evt_o.done     = rsp_hit;
    if (to_hit) begin
      evt_o.evt_id   = ld_q[to_idx].beat.id;
      evt_o.evt_addr = ld_q[to_idx].beat.addr;
    end else if (comp_beat && !rsp_found) begin
      evt_o.evt_id = slv_rsp_i.r_id;
    end
    if (rsp_hit) begin
      evt_o.latency = ld_q[rsp_head].counter;
    end
  end

  // Held until software clears it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reset_req_q <= 1'b0;
    end else if (flush) begin
      reset_req_q <= 1'b1;
    end else if (cfg_i.clear) begin
      reset_req_q <= 1'b0;
    end
  end

  assign reset_req_o = reset_req_q;

endmodule

`default_nettype wire

//--- logic/guard_tick.sv
/*
 * Prescaler for the budget countdown, one-cycle tick every PrescalerDiv cycles
 */
`timescale 1ns/1ps
`default_nettype none

module guard_tick #(
  parameter int unsigned PrescalerDiv = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic tick_o
);

  localparam int unsigned DivW = (PrescalerDiv > 1) ? $clog2(PrescalerDiv) : 1;
  localparam logic [DivW-1:0] LastCnt = DivW'(PrescalerDiv - 1);

  logic [DivW-1:0] div_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_q <= '0;
    end else if (div_q == LastCnt) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  // Tick on the last count of each period
  assign tick_o = (div_q == LastCnt);

endmodule

`default_nettype wire

//--- logic/guard_pkg.sv
/*
 * Shared types of the AXI read guard: vector typedefs, reduced AXI read
 * channel structs, Wishbone structs and the guard/register exchange structs
 */
`default_nettype none

package guard_pkg;

  // Widths with a meaning of their own
  typedef logic [3:0]  id_t;
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  len_t;
  typedef logic [15:0] cnt_t;
  typedef logic [7:0]  wb_addr_t;
  typedef logic [31:0] wb_data_t;

  // Read address beat, 44 bits
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_beat_t;

  // Master side of the tapped read path
  typedef struct packed {
    ar_beat_t ar;
    logic     ar_valid;
    logic     r_ready;
  } rd_req_t;

  // Slave side of the tapped read path
  typedef struct packed {
    logic ar_ready;
    id_t  r_id;
    logic r_last;
    logic r_valid;
  } rd_rsp_t;

  // Register file to guard
  typedef struct packed {
    cnt_t budget;
    logic clear;
  } guard_cfg_t;

  // Guard to register file, flags are single-cycle
  typedef struct packed {
    logic  timeout;
    logic  unwanted;
    logic  done;
    id_t   evt_id;
    addr_t evt_addr;
    cnt_t  latency;
  } guard_evt_t;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

endpackage

`default_nettype wire
